// File: tiled_ram_pkg.sv
// Limits: byte addresses with the low two bits ignored, whole-word access only, at most 1024 words
`default_nettype none

package tiled_ram_pkg;

  // ----------------------------------------------------------------------
  // Bus and word sizes
  // ----------------------------------------------------------------------

  // APB byte address width
  localparam int APB_ADDR_WIDTH = 12;

  // Data word carried on pwdata and prdata
  localparam int WORD_WIDTH = 32;

  typedef logic [WORD_WIDTH-1:0] word_t;

  // ----------------------------------------------------------------------
  // Sizing helpers
  // ----------------------------------------------------------------------

  // Index bits for a count, never less than one bit
  function automatic int clamped_clog2(input int value);
    return (value <= 2) ? 1 : $clog2(value);
  endfunction

  // Rounded-up quotient, gives the depth of one tile
  function automatic int ceil_div(input int num, input int den);
    return (num + den - 1) / den;
  endfunction

  // True for 1, 2, 4, 8 and so on
  function automatic bit is_power_of_2(input int value);
    return (value > 0) && ((value & (value - 1)) == 0);
  endfunction

endpackage

`default_nettype wire

// File: valid_delay.sv
// Only the valid bits are reset, payload registers start unknown, zero stages is a plain wire path
`timescale 1ns/1ps
`default_nettype none

module valid_delay #(
  // Number of register stages, zero gives a wire path
  parameter int NumStages = 1,
  // Payload carried alongside valid
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      in_valid,
  input  payload_t in_payload,
  output logic     out_valid,
  output payload_t out_payload
);

  if (NumStages == 0) begin : gen_passthru
    // Combinational path, clk and rst are not needed here
    assign out_valid   = in_valid;
    assign out_payload = in_payload;

  end else begin : gen_stages
    logic [NumStages-1:0] valid_q;
    payload_t             payload_q [NumStages];

    // Valid shift chain
    always_ff @(posedge clk) begin
      if (rst) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int s = 1; s < NumStages; s++) begin
          valid_q[s] <= valid_q[s-1];
        end
      end
    end

    // Payload shift chain, no reset
    always_ff @(posedge clk) begin
      payload_q[0] <= in_payload;
      for (int s = 1; s < NumStages; s++) begin
        payload_q[s] <= payload_q[s-1];
      end
    end

    assign out_valid   = valid_q[NumStages-1];
    assign out_payload = payload_q[NumStages-1];
  end

endmodule

`default_nettype wire

// File: ram_addr_decoder.sv
// Tiles must divide Depth evenly and in_addr must be below Depth whenever in_valid is high
`timescale 1ns/1ps
`default_nettype none

module ram_addr_decoder #(
  parameter int Depth     = 24,
  parameter int Tiles     = 3,
  parameter int Stages    = 1,
  parameter int DataWidth = tiled_ram_pkg::WORD_WIDTH,
  localparam int TileDepth    = tiled_ram_pkg::ceil_div(Depth, Tiles),
  localparam int InAddrWidth  = tiled_ram_pkg::clamped_clog2(Depth),
  localparam int OutAddrWidth = tiled_ram_pkg::clamped_clog2(TileDepth)
) (
  input  wire                                     clk,
  input  wire                                     rst,
  // Request side
  input  wire                                     in_valid,
  input  wire  [InAddrWidth-1:0]                  in_addr,
  input  wire                                     in_data_valid,
  input  wire  [DataWidth-1:0]                    in_data,
  // Per-tile side, address is local to the tile
  output logic [Tiles-1:0]                        out_valid,
  output logic [Tiles-1:0][OutAddrWidth-1:0]      out_addr,
  output logic [Tiles-1:0]                        out_data_valid,
  output logic [Tiles-1:0][DataWidth-1:0]         out_data
);

  typedef logic [OutAddrWidth-1:0] tile_addr_t;
  typedef logic [DataWidth-1:0]    tile_data_t;

  // Decoded request before retiming
  logic [Tiles-1:0]   dec_valid;
  tile_addr_t         dec_addr [Tiles];

  // ----------------------------------------------------------------------
  // Tile select
  // ----------------------------------------------------------------------

  if (Tiles == 1) begin : gen_single
    // One tile, address passes unchanged
    assign dec_valid[0] = in_valid;
    assign dec_addr[0]  = in_addr;

  end else if (tiled_ram_pkg::is_power_of_2(Depth)) begin : gen_msb_select
    localparam int SelWidth = $clog2(Tiles);
    localparam int SelLsb   = InAddrWidth - SelWidth;

    logic [SelWidth-1:0] tile_sel;
    tile_addr_t          local_addr;

    // Upper bits pick the tile
    assign tile_sel = in_addr[InAddrWidth-1:SelLsb];

    // Lower bits index inside it, single-entry tiles always use entry 0
    assign local_addr = (TileDepth > 1) ? in_addr[OutAddrWidth-1:0] : '0;

    for (genvar i = 0; i < Tiles; i++) begin : gen_tile
      assign dec_valid[i] = in_valid && (tile_sel == SelWidth'(i));
      assign dec_addr[i]  = local_addr;
    end

  end else begin : gen_range_compare
    // Depth not a power of 2, so each tile checks its own window
    for (genvar i = 0; i < Tiles; i++) begin : gen_tile
      localparam int Base  = TileDepth * i;
      localparam int Bound = TileDepth * (i + 1);

      logic [InAddrWidth-1:0] offset;

      // Base is inclusive, bound exclusive
      assign dec_valid[i] = in_valid &&
                            (int'(in_addr) >= Base) && (int'(in_addr) < Bound);

      // Offset from the tile base, upper bits are zero inside the window
      assign offset      = in_addr - InAddrWidth'(Base);
      assign dec_addr[i] = offset[OutAddrWidth-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Per-tile retiming
  // ----------------------------------------------------------------------

  // Separate registers per tile keep fanout low
  for (genvar i = 0; i < Tiles; i++) begin : gen_out
    logic dec_data_valid;

    // Write data only goes to the selected tile
    assign dec_data_valid = dec_valid[i] && in_data_valid;

    valid_delay #(
      .NumStages(Stages),
      .payload_t(tile_addr_t)
    ) u_addr_delay (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (dec_valid[i]),
      .in_payload (dec_addr[i]),
      .out_valid  (out_valid[i]),
      .out_payload(out_addr[i])
    );

    valid_delay #(
      .NumStages(Stages),
      .payload_t(tile_data_t)
    ) u_data_delay (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (dec_data_valid),
      .in_payload (in_data),
      .out_valid  (out_data_valid[i]),
      .out_payload(out_data[i])
    );
  end

endmodule

`default_nettype wire

// File: ram_tile.sv
// Contents are not reset and a read of an unwritten entry returns unknown data
`timescale 1ns/1ps
`default_nettype none

module ram_tile #(
  parameter int TileDepth = 8,
  parameter int DataWidth = $bits(tiled_ram_pkg::word_t),
  localparam int AddrWidth = tiled_ram_pkg::clamped_clog2(TileDepth)
) (
  input  wire                  clk,
  input  wire                  tile_valid,
  // High for a write, low for a read
  input  wire                  tile_wr,
  input  wire  [AddrWidth-1:0] tile_addr,
  input  wire  [DataWidth-1:0] tile_wdata,
  output logic [DataWidth-1:0] rd_data
);

  // Flop storage
  logic [DataWidth-1:0] mem [TileDepth];

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (tile_valid && tile_wr) begin
      mem[tile_addr] <= tile_wdata;
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------

  // One cycle latency, holds the last word between reads
  always_ff @(posedge clk) begin
    if (tile_valid && !tile_wr) begin
      rd_data <= mem[tile_addr];
    end
  end

endmodule

`default_nettype wire

// File: read_return_mux.sv
// Expects at most one tile read request per cycle and a tile read latency of one cycle
`timescale 1ns/1ps
`default_nettype none

module read_return_mux #(
  parameter int Tiles     = 3,
  parameter int DataWidth = $bits(tiled_ram_pkg::word_t),
  localparam int SelWidth = tiled_ram_pkg::clamped_clog2(Tiles)
) (
  input  wire                              clk,
  input  wire                              rst,
  // One-hot read request, same cycle as the tile request
  input  wire  [Tiles-1:0]                 tile_rd_req,
  input  wire  [Tiles-1:0][DataWidth-1:0]  tile_rd_data,
  output logic                             rd_valid,
  output logic [DataWidth-1:0]             rd_data
);

  logic [Tiles-1:0]    req_q;
  logic [SelWidth-1:0] sel_idx;

  // Request delayed to line up with the tile read data
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else begin
      req_q <= tile_rd_req;
    end
  end

  // One-hot to index
  always_comb begin
    sel_idx = '0;
    for (int t = 0; t < Tiles; t++) begin
      if (req_q[t]) begin
        sel_idx = SelWidth'(t);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Return path
  // ----------------------------------------------------------------------

  assign rd_valid = |req_q;
  // Index stays in range, it defaults to tile 0 when idle
  assign rd_data  = tile_rd_data[sel_idx];

endmodule

`default_nettype wire

// File: apb_ram_ctrl.sv
// Word-only APB slave without pstrb or pprot, Depth at most 1024, reads wait on rd_valid
`timescale 1ns/1ps
`default_nettype none

module apb_ram_ctrl #(
  parameter int Depth = 24,
  localparam int ReqAddrWidth = tiled_ram_pkg::clamped_clog2(Depth)
) (
  input  wire                                          clk,
  input  wire                                          rst,
  // APB slave
  input  wire                                          psel,
  input  wire                                          penable,
  input  wire                                          pwrite,
  input  wire  [tiled_ram_pkg::APB_ADDR_WIDTH-1:0]     paddr,
  input  tiled_ram_pkg::word_t                         pwdata,
  output tiled_ram_pkg::word_t                         prdata,
  output logic                                         pready,
  output logic                                         pslverr,
  // Request into the decoder
  output logic                                         req_valid,
  output logic [ReqAddrWidth-1:0]                      req_addr,
  output logic                                         req_wr,
  output tiled_ram_pkg::word_t                         req_wdata,
  // Read return
  input  wire                                          rd_valid,
  input  tiled_ram_pkg::word_t                         rd_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_RD,
    ST_DONE
  } state_e;

  state_e state;
  state_e state_next;

  logic [tiled_ram_pkg::APB_ADDR_WIDTH-3:0] word_idx;
  logic                                     in_range;
  logic                                     setup;

  // Byte address to word index
  assign word_idx = paddr[tiled_ram_pkg::APB_ADDR_WIDTH-1:2];
  assign in_range = int'(word_idx) < Depth;
  assign setup    = psel && !penable;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // Range decided from the setup cycle address
      ST_IDLE:    if (setup) state_next = in_range ? ST_ISSUE : ST_DONE;
      // Writes are posted and finish here
      ST_ISSUE:   state_next = pwrite ? ST_IDLE : ST_WAIT_RD;
      ST_WAIT_RD: if (rd_valid) state_next = ST_IDLE;
      // Error completion
      ST_DONE:    state_next = ST_IDLE;
      default:    state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------

  // One request, in the first access cycle
  assign req_valid = (state == ST_ISSUE);
  assign req_addr  = word_idx[ReqAddrWidth-1:0];
  assign req_wr    = req_valid && pwrite;
  assign req_wdata = pwdata;

  assign pready = ((state == ST_ISSUE) && pwrite) ||
                  ((state == ST_WAIT_RD) && rd_valid) ||
                  (state == ST_DONE);

  assign pslverr = (state == ST_DONE);

  // Zero unless read data is returning
  assign prdata = ((state == ST_WAIT_RD) && rd_valid) ? rd_data : '0;

endmodule

`default_nettype wire

// File: tiled_ram_top.sv
// DataWidth must equal the package word width and Tiles must divide Depth evenly
`timescale 1ns/1ps
`default_nettype none

module tiled_ram_top #(
  parameter int Depth     = 24,
  parameter int Tiles     = 3,
  parameter int Stages    = 1,
  parameter int DataWidth = tiled_ram_pkg::WORD_WIDTH,
  localparam int TileDepth     = tiled_ram_pkg::ceil_div(Depth, Tiles),
  localparam int ReqAddrWidth  = tiled_ram_pkg::clamped_clog2(Depth),
  localparam int TileAddrWidth = tiled_ram_pkg::clamped_clog2(TileDepth)
) (
  input  wire                                      clk,
  input  wire                                      rst,
  // APB slave
  input  wire                                      psel,
  input  wire                                      penable,
  input  wire                                      pwrite,
  input  wire  [tiled_ram_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  tiled_ram_pkg::word_t                     pwdata,
  output tiled_ram_pkg::word_t                     prdata,
  output logic                                     pready,
  output logic                                     pslverr
);

  // Controller to decoder
  logic                      req_valid;
  logic [ReqAddrWidth-1:0]   req_addr;
  logic                      req_wr;
  tiled_ram_pkg::word_t      req_wdata;

  // Decoder to tiles
  logic [Tiles-1:0]                     tile_valid;
  logic [Tiles-1:0][TileAddrWidth-1:0]  tile_addr;
  logic [Tiles-1:0]                     tile_wr;
  logic [Tiles-1:0][DataWidth-1:0]      tile_wdata;

  // Tiles to return mux
  logic [Tiles-1:0]                     tile_rd_req;
  logic [Tiles-1:0][DataWidth-1:0]      tile_rd_data;
  logic                                 rd_valid;
  tiled_ram_pkg::word_t                 rd_data;

  apb_ram_ctrl #(
    .Depth(Depth)
  ) u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .req_valid(req_valid),
    .req_addr (req_addr),
    .req_wr   (req_wr),
    .req_wdata(req_wdata),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  ram_addr_decoder #(
    .Depth    (Depth),
    .Tiles    (Tiles),
    .Stages   (Stages),
    .DataWidth(DataWidth)
  ) u_decoder (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (req_valid),
    .in_addr       (req_addr),
    .in_data_valid (req_wr),
    .in_data       (req_wdata),
    .out_valid     (tile_valid),
    .out_addr      (tile_addr),
    .out_data_valid(tile_wr),
    .out_data      (tile_wdata)
  );

  for (genvar i = 0; i < Tiles; i++) begin : gen_tile
    // Read request is a valid without write
    assign tile_rd_req[i] = tile_valid[i] && !tile_wr[i];

    ram_tile #(
      .TileDepth(TileDepth),
      .DataWidth(DataWidth)
    ) u_tile (
      .clk       (clk),
      .tile_valid(tile_valid[i]),
      .tile_wr   (tile_wr[i]),
      .tile_addr (tile_addr[i]),
      .tile_wdata(tile_wdata[i]),
      .rd_data   (tile_rd_data[i])
    );
  end

  read_return_mux #(
    .Tiles    (Tiles),
    .DataWidth(DataWidth)
  ) u_rd_mux (
    .clk         (clk),
    .rst         (rst),
    .tile_rd_req (tile_rd_req),
    .tile_rd_data(tile_rd_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data)
  );

endmodule

`default_nettype wire

// File: tiled_ram_checker.sv
// Checks decoder outputs only, sampled on rising clk and skipped while rst is high
`timescale 1ns/1ps
`default_nettype none

module tiled_ram_checker #(
  parameter int Tiles     = 3,
  parameter int TileDepth = 8,
  parameter int AddrWidth = 3
) (
  input wire                             clk,
  input wire                             rst,
  input wire [Tiles-1:0]                 out_valid,
  input wire [Tiles-1:0][AddrWidth-1:0]  out_addr,
  input wire [Tiles-1:0]                 out_data_valid
);

  // Failure tally, read back by the testbench at the end
  int fail_count = 0;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Every valid tile must point inside its own storage
  function automatic bit tile_addrs_ok(input logic [Tiles-1:0] valid,
                                       input logic [Tiles-1:0][AddrWidth-1:0] addr);
    bit ok;
    ok = 1'b1;
    for (int t = 0; t < Tiles; t++) begin
      if (valid[t] && (int'(addr[t]) >= TileDepth)) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // At most one tile per cycle
  a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(out_valid))
    else begin
      fail_count++;
      $error("more than one tile valid in the same cycle");
    end

  a_local_addr: assert property (@(posedge clk) disable iff (rst)
                                 tile_addrs_ok(out_valid, out_addr))
    else begin
      fail_count++;
      $error("tile-local address beyond the tile depth");
    end

  // Write data never goes to an idle tile
  a_data_valid: assert property (@(posedge clk) disable iff (rst)
                                 (out_data_valid & ~out_valid) == '0)
    else begin
      fail_count++;
      $error("data valid on a tile without a request");
    end

endmodule

bind ram_addr_decoder tiled_ram_checker #(
  .Tiles    (Tiles),
  .TileDepth(TileDepth),
  .AddrWidth(OutAddrWidth)
) u_checker (
  .clk           (clk),
  .rst           (rst),
  .out_valid     (out_valid),
  .out_addr      (out_addr),
  .out_data_valid(out_data_valid)
);

`default_nettype wire

// File: tiled_ram_tb.sv
// Default parameters only (Depth 24, Tiles 3, Stages 1), reads touch only indices written earlier
`timescale 1ns/1ps
`default_nettype none

module tiled_ram_tb;

  localparam int Depth         = 24;
  localparam int Stages        = 1;
  localparam int AddrWidth     = tiled_ram_pkg::APB_ADDR_WIDTH;
  localparam int TimeoutCycles = 3000;
  localparam int unsigned Seed = 32'h880d7bd0;

  // One completed APB transfer as seen on the bus
  typedef struct {
    bit                   wr;
    int                   idx;
    tiled_ram_pkg::word_t wdata;
    tiled_ram_pkg::word_t rdata;
    logic                 err;
    int                   waits;
  } xfer_t;

  logic                  clk;
  logic                  rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [AddrWidth-1:0]  paddr;
  tiled_ram_pkg::word_t  pwdata;
  tiled_ram_pkg::word_t  prdata;
  logic                  pready;
  logic                  pslverr;

  // Reference memory, indexed by word
  tiled_ram_pkg::word_t model [int];
  xfer_t                done_q [$];
  int                   errors;
  int                   check_count;
  int                   cycle_count;

  tiled_ram_top uut (
    .clk    (clk),
    .rst    (rst),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Out of range is any word index at or above Depth
  function automatic logic expected_err(input int idx);
    return idx >= Depth;
  endfunction

  // Errors return zero, in-range reads return the last word written
  function automatic tiled_ram_pkg::word_t expected_rdata(input int idx);
    if (idx >= Depth) begin
      return '0;
    end
    return model[idx];
  endfunction

  // ----------------------------------------------------------------------
  // APB driver
  // ----------------------------------------------------------------------

  // Setup, access until pready, then back to idle; outputs sampled mid-cycle
  task automatic apb_transfer(input bit wr, input int idx, input tiled_ram_pkg::word_t wdata,
                              input logic [1:0] byte_off);
    xfer_t x;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= AddrWidth'(idx * 4 + int'(byte_off));
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    x.waits = 0;
    @(negedge clk);
    while (pready !== 1'b1) begin
      x.waits++;
      @(negedge clk);
    end
    x.wr    = wr;
    x.idx   = idx;
    x.wdata = wdata;
    x.rdata = prdata;
    x.err   = pslverr;
    done_q.push_back(x);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Compare
  // ----------------------------------------------------------------------

  task automatic check_transfer(input xfer_t x);
    logic                 exp_err;
    tiled_ram_pkg::word_t exp_data;
    int                   exp_waits;
    exp_err   = expected_err(x.idx);
    // Posted writes and errors finish in the first access cycle
    exp_waits = (exp_err || x.wr) ? 0 : Stages + 1;
    check_count++;
    if (x.err !== exp_err) begin
      errors++;
      $display("Error: pslverr index %0d expected %h got %h", x.idx, exp_err, x.err);
    end
    if (x.waits != exp_waits) begin
      errors++;
      $display("Error: pready delay index %0d expected %h got %h", x.idx, exp_waits, x.waits);
    end
    if (x.wr && !exp_err) begin
      model[x.idx] = x.wdata;
    end else if (!exp_err && !model.exists(x.idx)) begin
      errors++;
      $display("Read of index %0d has no written value in the reference model", x.idx);
    end else begin
      exp_data = expected_rdata(x.idx);
      if (x.rdata !== exp_data) begin
        errors++;
        $display("Error: prdata index %0d expected %h got %h", x.idx, exp_data, x.rdata);
      end
    end
  endtask

  always @(posedge clk) begin
    while (done_q.size() > 0) begin
      check_transfer(done_q.pop_front());
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    int alias_idx;
    int assert_fails;
    void'($urandom(Seed));
    errors      = 0;
    check_count = 0;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Idle bus after reset
    repeat (4) begin
      @(negedge clk);
      check_count++;
      if (pready !== 1'b0) begin
        errors++;
        $display("Error: pready expected %h got %h", 1'b0, pready);
      end
      if (pslverr !== 1'b0) begin
        errors++;
        $display("Error: pslverr expected %h got %h", 1'b0, pslverr);
      end
    end

    // Fill every index, crossing tile edges at 7/8 and 15/16
    for (int i = 0; i < Depth; i++) begin
      apb_transfer(1'b1, i, 32'hc0de_0000 + i * 32'h0001_0011, 2'b00);
    end
    for (int i = 0; i < Depth; i++) begin
      apb_transfer(1'b0, i, '0, 2'b00);
    end

    // Out of range, then the low indices they might alias onto
    for (int i = Depth; i < Depth + 10; i++) begin
      alias_idx = (i == Depth + 8) ? 1023 : (i == Depth + 9) ? 100 : i;
      apb_transfer(1'b1, alias_idx, 32'hdead_0000 + alias_idx, 2'b00);
      apb_transfer(1'b0, alias_idx, '0, 2'b00);
      apb_transfer(1'b0, alias_idx % Depth, '0, 2'b00);
      apb_transfer(1'b0, alias_idx % 8, '0, 2'b00);
    end

    // Random mix, low byte-address bits should be ignored
    for (int n = 0; n < 300; n++) begin
      apb_transfer(1'($urandom_range(1, 0)), int'($urandom_range(Depth - 1, 0)),
                   $urandom(), 2'($urandom_range(3, 0)));
    end

    wait (done_q.size() == 0);
    @(negedge clk);
    assert_fails = uut.u_decoder.u_checker.fail_count;
    $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
             check_count, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
tiled_ram_pkg.sv
valid_delay.sv
ram_addr_decoder.sv
ram_tile.sv
read_return_mux.sv
apb_ram_ctrl.sv
tiled_ram_top.sv
tiled_ram_checker.sv
tiled_ram_tb.sv
